//--- mem_geom_pkg.sv
package mem_geom_pkg;

  // Scratchpad line geometry
  localparam int LINE_BYTES = 16;
  localparam int DATA_WIDTH = 8 * LINE_BYTES;
  localparam int MASK_BITS  = 4;

  // 16 KB byte space, two line-interleaved banks
  localparam int ADDR_WIDTH      = 14;
  localparam int LINE_ADDR_WIDTH = ADDR_WIDTH - MASK_BITS;

  // Each bank holds two blocks of 256 lines
  localparam int MEM_LINES      = 256;
  localparam int MEM_ADDR_WIDTH = 8;
  localparam int MEM_SEL_BITS   = 1;
  localparam int MEM_BLOCKS     = 2 ** MEM_SEL_BITS;

  typedef logic [DATA_WIDTH-1:0] line_t;

  typedef logic [ADDR_WIDTH-1:0] byte_addr_t;

  // Bit 0 picks the bank, the top bit picks the block
  typedef logic [LINE_ADDR_WIDTH-1:0] line_addr_t;

  typedef logic [MEM_ADDR_WIDTH-1:0] blk_addr_t;

endpackage

//--- rd_stream_pkg.sv
package rd_stream_pkg;

  // Lengths run from 1 to 1023 bytes
  localparam int LEN_WIDTH = 10;

  // Up to 64 lines per descriptor
  localparam int LINE_CNT_WIDTH = 7;

  // Output FIFO depth, also the credit limit
  localparam int FIFO_LINES   = 4;
  localparam int CREDIT_WIDTH = $clog2(FIFO_LINES) + 1;

  typedef logic [LEN_WIDTH-1:0] byte_len_t;

  typedef logic [CREDIT_WIDTH-1:0] credit_t;

  typedef logic [mem_geom_pkg::MASK_BITS-1:0] empty_t;

  // One stream beat as stored in the output FIFO
  typedef struct packed {
    logic                last;
    empty_t              empty;
    mem_geom_pkg::line_t data;
  } beat_t;

endpackage

//--- bank_rd_if.sv
`timescale 1ns/100ps

interface bank_rd_if;
  import mem_geom_pkg::*;

  // One enable per block, one address per bank
  logic [MEM_BLOCKS-1:0] b1_en;
  blk_addr_t             b1_addr;
  line_t [MEM_BLOCKS-1:0] b1_data;

  logic [MEM_BLOCKS-1:0] b2_en;
  blk_addr_t             b2_addr;
  line_t [MEM_BLOCKS-1:0] b2_data;

  modport dma (
    output b1_en, b1_addr,
    output b2_en, b2_addr,
    input  b1_data, b2_data
  );

  modport mem (
    input  b1_en, b1_addr,
    input  b2_en, b2_addr,
    output b1_data, b2_data
  );

endinterface

//--- simple_fifo.sv
`timescale 1ns/100ps

module simple_fifo #(
  parameter int DEPTH_BITS = 2,
  parameter int WIDTH      = 8
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             clear,
  input  logic             din_valid,
  input  logic [WIDTH-1:0] din,
  output logic             din_ready,
  output logic             dout_valid,
  output logic [WIDTH-1:0] dout,
  input  logic             dout_ready
);

  logic [WIDTH-1:0]      ram [2**DEPTH_BITS];
  logic [DEPTH_BITS-1:0] wr_ptr;
  logic [DEPTH_BITS-1:0] rd_ptr;
  logic [DEPTH_BITS:0]   count;
  logic                  push;
  logic                  pop;

  // Top bit of count is set only when full
  assign din_ready  = !count[DEPTH_BITS];
  assign dout_valid = (count != '0);
  assign dout       = ram[rd_ptr];

  assign push = din_valid && din_ready;
  assign pop  = dout_valid && dout_ready;

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push)
      ram[wr_ptr] <= din;
  end

  a_no_write_when_full: assert property (
    @(posedge clk) disable iff (rst || clear) din_valid |-> din_ready
  ) else $error("simple_fifo: write while full");

endmodule

//--- scratch_mem.sv
`timescale 1ns/100ps

module scratch_mem (
  input  logic                clk,
  input  logic                rst,
  input  logic                wr_en,
  input  mem_geom_pkg::line_addr_t wr_addr,
  input  mem_geom_pkg::line_t wr_data,
  bank_rd_if.mem              rd
);
  import mem_geom_pkg::*;

  blk_addr_t wr_blk_addr;

  assign wr_blk_addr = wr_addr[MEM_ADDR_WIDTH:1];

  // Bank 0 is b1 (even lines), bank 1 is b2 (odd lines)
  for (genvar b = 0; b < 2; b++) begin : g_bank
    logic [MEM_BLOCKS-1:0] en;
    blk_addr_t             addr;

    if (b == 0) begin : g_b1
      assign en   = rd.b1_en;
      assign addr = rd.b1_addr;
    end else begin : g_b2
      assign en   = rd.b2_en;
      assign addr = rd.b2_addr;
    end

    for (genvar k = 0; k < MEM_BLOCKS; k++) begin : g_blk
      line_t ram [MEM_LINES];
      line_t ram_q;
      line_t out_q;
      logic  en_q;
      logic  wr_hit;

      assign wr_hit = wr_en && (wr_addr[0] == 1'(b))
                      && (wr_addr[LINE_ADDR_WIDTH-1 -: MEM_SEL_BITS] == MEM_SEL_BITS'(k));

      always_ff @(posedge clk) begin
        if (wr_hit)
          ram[wr_blk_addr] <= wr_data;
        if (en[k])
          ram_q <= ram[addr];
        // Output stage holds its value between reads
        if (en_q)
          out_q <= ram_q;
      end

      always_ff @(posedge clk) begin
        if (rst)
          en_q <= 1'b0;
        else
          en_q <= en[k];
      end

      if (b == 0) begin : g_out_b1
        assign rd.b1_data[k] = out_q;
      end else begin : g_out_b2
        assign rd.b2_data[k] = out_q;
      end
    end
  end

endmodule

//--- single_accel_rd_dma.sv
`timescale 1ns/100ps

module single_accel_rd_dma (
  input  logic                     clk,
  input  logic                     rst,
  input  mem_geom_pkg::byte_addr_t desc_addr,
  input  rd_stream_pkg::byte_len_t desc_len,
  input  logic                     desc_valid,
  output logic                     desc_ready,
  input  logic                     accel_stop,
  bank_rd_if.dma                   mem,
  output mem_geom_pkg::line_t      m_axis_tdata,
  output rd_stream_pkg::empty_t    m_axis_tempty,
  output logic                     m_axis_tlast,
  output logic                     m_axis_tvalid,
  input  logic                     m_axis_tready
);
  import mem_geom_pkg::*;
  import rd_stream_pkg::*;

  // Side information that follows each line read
  typedef struct packed {
    logic                    last;
    empty_t                  empty;
    logic                    bank;
    logic [MASK_BITS-1:0]    offset;
    logic [MEM_SEL_BITS-1:0] b1_sel;
    logic [MEM_SEL_BITS-1:0] b2_sel;
  } meta_t;

  line_addr_t                req_line;
  logic [MASK_BITS-1:0]      req_offset;
  logic [MASK_BITS-1:0]      req_rem;
  logic [LINE_CNT_WIDTH-1:0] req_count;
  empty_t                    req_final_empty;

  line_addr_t                act_line;
  line_addr_t                act_line_nxt;
  logic [LINE_CNT_WIDTH-1:0] act_count;
  logic [MASK_BITS-1:0]      act_offset;
  empty_t                    act_final_empty;
  logic                      act_valid;
  logic                      act_last;

  logic                      stop_q;
  credit_t                   credit;
  logic                      issue;
  logic                      desc_fire;
  logic                      beat_pop;

  line_addr_t                b1_line;
  line_addr_t                b2_line;
  logic [MEM_BLOCKS-1:0]     b1_en_q;
  logic [MEM_BLOCKS-1:0]     b2_en_q;
  blk_addr_t                 b1_addr_q;
  blk_addr_t                 b2_addr_q;
  logic [3:0]                rd_vld;
  meta_t                     meta [4];

  line_t                     b1_word;
  line_t                     b2_word;
  logic [2*DATA_WIDTH-1:0]   pair;
  logic [2*DATA_WIDTH-1:0]   pair_shift;
  line_t                     aligned_q;

  beat_t                     in_beat;
  beat_t                     out_beat;
  logic                      fifo_din_ready;

  // Descriptor parsing
  assign req_line        = desc_addr[ADDR_WIDTH-1:MASK_BITS];
  assign req_offset      = desc_addr[MASK_BITS-1:0];
  assign req_rem         = desc_len[MASK_BITS-1:0];
  assign req_count       = LINE_CNT_WIDTH'(desc_len[LEN_WIDTH-1:MASK_BITS])
                           + LINE_CNT_WIDTH'(req_rem != '0);
  assign req_final_empty = (req_rem == '0) ? '0 : empty_t'(LINE_BYTES - req_rem);

  assign act_line_nxt = act_line + 1'b1;
  assign act_last     = (act_count == LINE_CNT_WIDTH'(1));
  assign issue        = act_valid && (credit < credit_t'(FIFO_LINES));
  assign desc_ready   = !act_valid || (issue && act_last);
  assign desc_fire    = desc_valid && desc_ready;
  assign beat_pop     = m_axis_tvalid && m_axis_tready;

  always_ff @(posedge clk) begin
    if (desc_fire) begin
      act_line        <= req_line;
      act_count       <= req_count;
      act_offset      <= req_offset;
      act_final_empty <= req_final_empty;
    end else if (issue) begin
      act_line  <= act_line_nxt;
      act_count <= act_count - 1'b1;
    end
  end

  // A new descriptor wins over a pending stop
  always_ff @(posedge clk) begin
    if (rst) begin
      act_valid <= 1'b0;
      stop_q    <= 1'b0;
      credit    <= '0;
    end else begin
      if (desc_fire)
        act_valid <= 1'b1;
      else if (stop_q || (issue && act_last))
        act_valid <= 1'b0;

      if (desc_valid)
        stop_q <= 1'b0;
      else if (accel_stop)
        stop_q <= 1'b1;

      if (stop_q)
        credit <= '0;
      else if (issue && !beat_pop)
        credit <= credit + 1'b1;
      else if (beat_pop && !issue)
        credit <= credit - 1'b1;
    end
  end

  // Current line goes to its own bank, the next line to the other one
  assign b1_line = act_line[0] ? act_line_nxt : act_line;
  assign b2_line = act_line[0] ? act_line : act_line_nxt;

  always_ff @(posedge clk) begin
    if (rst) begin
      b1_en_q <= '0;
      b2_en_q <= '0;
      rd_vld  <= '0;
    end else begin
      b1_en_q <= '0;
      b2_en_q <= '0;
      if (issue) begin
        b1_en_q[b1_line[LINE_ADDR_WIDTH-1 -: MEM_SEL_BITS]] <= 1'b1;
        b2_en_q[b2_line[LINE_ADDR_WIDTH-1 -: MEM_SEL_BITS]] <= 1'b1;
      end
      rd_vld <= {rd_vld[2:0], issue};
    end
  end

  always_ff @(posedge clk) begin
    b1_addr_q      <= b1_line[MEM_ADDR_WIDTH:1];
    b2_addr_q      <= b2_line[MEM_ADDR_WIDTH:1];
    meta[0].last   <= act_last;
    meta[0].empty  <= act_last ? act_final_empty : '0;
    meta[0].bank   <= act_line[0];
    meta[0].offset <= act_offset;
    meta[0].b1_sel <= b1_line[LINE_ADDR_WIDTH-1 -: MEM_SEL_BITS];
    meta[0].b2_sel <= b2_line[LINE_ADDR_WIDTH-1 -: MEM_SEL_BITS];
    for (int i = 1; i < 4; i++)
      meta[i] <= meta[i-1];
    aligned_q <= pair_shift[DATA_WIDTH-1:0];
  end

  assign mem.b1_en   = b1_en_q;
  assign mem.b2_en   = b2_en_q;
  assign mem.b1_addr = b1_addr_q;
  assign mem.b2_addr = b2_addr_q;

  // Memory data is valid two edges after the enables, meta[2] lines up with it
  always_comb begin
    b1_word    = mem.b1_data[meta[2].b1_sel];
    b2_word    = mem.b2_data[meta[2].b2_sel];
    pair       = meta[2].bank ? {b1_word, b2_word} : {b2_word, b1_word};
    pair_shift = pair >> {meta[2].offset, 3'b000};
  end

  always_comb begin
    in_beat.last  = meta[3].last;
    in_beat.empty = meta[3].empty;
    in_beat.data  = aligned_q;
  end

  simple_fifo #(
    .DEPTH_BITS ($clog2(FIFO_LINES)),
    .WIDTH      ($bits(beat_t))
  ) accel_fifo (
    .clk        (clk),
    .rst        (rst),
    .clear      (stop_q),
    .din_valid  (rd_vld[3]),
    .din        (in_beat),
    .din_ready  (fifo_din_ready),
    .dout_valid (m_axis_tvalid),
    .dout       (out_beat),
    .dout_ready (m_axis_tready)
  );

  assign m_axis_tdata  = out_beat.data;
  assign m_axis_tempty = out_beat.empty;
  assign m_axis_tlast  = out_beat.last;

  a_desc_len_nonzero: assert property (
    @(posedge clk) disable iff (rst) desc_fire |-> (desc_len != '0)
  ) else $error("single_accel_rd_dma: zero length descriptor");

  // Credits must keep the FIFO from filling up under the read pipeline
  a_credit_no_overflow: assert property (
    @(posedge clk) disable iff (rst) rd_vld[3] |-> fifo_din_ready
  ) else $error("single_accel_rd_dma: FIFO written while full");

  a_bank_en_onehot: assert property (
    @(posedge clk) disable iff (rst) $onehot0(mem.b1_en) && $onehot0(mem.b2_en)
  ) else $error("single_accel_rd_dma: more than one block enabled in a bank");

endmodule

//--- accel_rd_top.sv
`timescale 1ns/100ps

module accel_rd_top (
  input  logic                       clk,
  input  logic                       rst,

  input  logic                       wr_en,
  input  mem_geom_pkg::line_addr_t   wr_addr,
  input  mem_geom_pkg::line_t        wr_data,

  input  mem_geom_pkg::byte_addr_t   desc_addr,
  input  rd_stream_pkg::byte_len_t   desc_len,
  input  logic                       desc_valid,
  output logic                       desc_ready,

  input  logic                       accel_stop,

  output mem_geom_pkg::line_t        m_axis_tdata,
  output rd_stream_pkg::empty_t      m_axis_tempty,
  output logic                       m_axis_tlast,
  output logic                       m_axis_tvalid,
  input  logic                       m_axis_tready
);

  bank_rd_if bank_rd ();

  scratch_mem u_mem (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd      (bank_rd.mem)
  );

  single_accel_rd_dma u_dma (
    .clk           (clk),
    .rst           (rst),
    .desc_addr     (desc_addr),
    .desc_len      (desc_len),
    .desc_valid    (desc_valid),
    .desc_ready    (desc_ready),
    .accel_stop    (accel_stop),
    .mem           (bank_rd.dma),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tempty (m_axis_tempty),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready)
  );

endmodule

//--- tb_accel_rd.sv
`timescale 1ns/100ps

module tb_accel_rd;
  import mem_geom_pkg::*;
  import rd_stream_pkg::*;

  localparam int NUM_LINES      = 2 ** LINE_ADDR_WIDTH;
  localparam int MEM_BYTES      = 2 ** ADDR_WIDTH;
  localparam int NUM_RAND       = 8;
  localparam int NUM_DESC       = 19 + NUM_RAND;
  localparam int TIMEOUT_CYCLES = 10 + NUM_LINES + 200 * NUM_DESC;

  // Expected beat with a mask over the bytes inside the length
  typedef struct packed {
    line_t  data;
    line_t  mask;
    logic   last;
    empty_t empty;
  } exp_beat_t;

  logic       clk;
  logic       rst;
  logic       wr_en;
  line_addr_t wr_addr;
  line_t      wr_data;
  byte_addr_t desc_addr;
  byte_len_t  desc_len;
  logic       desc_valid;
  logic       desc_ready;
  logic       accel_stop;
  line_t      m_axis_tdata;
  empty_t     m_axis_tempty;
  logic       m_axis_tlast;
  logic       m_axis_tvalid;
  logic       m_axis_tready;

  logic [7:0]  mem_bytes [MEM_BYTES];
  exp_beat_t   exp_q [$];
  exp_beat_t   exp_head;
  logic        exp_valid;
  logic        stop_seen;
  logic        quiet;
  logic        rand_ready;
  logic        beat_fire;
  logic [31:0] lfsr;
  int          beat_count;
  int          err_data;
  int          err_last;
  int          err_empty;
  int          err_stable;
  int          err_flow;
  byte_addr_t  rnd_addr [NUM_RAND];
  byte_len_t   rnd_len [NUM_RAND];

  accel_rd_top u_dut (.*);

  always #50 clk = ~clk;

  assign beat_fire = m_axis_tvalid && m_axis_tready;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v[i] = lfsr[0];
    end
  endtask

  task automatic push_expected(input byte_addr_t addr, input byte_len_t len);
    int        nbeats;
    int        pos;
    exp_beat_t b;
    nbeats = (int'(len) + LINE_BYTES - 1) / LINE_BYTES;
    for (int i = 0; i < nbeats; i++) begin
      b = '0;
      for (int j = 0; j < LINE_BYTES; j++) begin
        pos = LINE_BYTES * i + j;
        b.data[8*j +: 8] = mem_bytes[(int'(addr) + pos) % MEM_BYTES];
        b.mask[8*j +: 8] = (pos < int'(len)) ? 8'hff : 8'h00;
      end
      b.last = (i == nbeats - 1);
      if (b.last && (int'(len) % LINE_BYTES != 0))
        b.empty = empty_t'(LINE_BYTES - int'(len) % LINE_BYTES);
      exp_q.push_back(b);
    end
  endtask

  // Reference model that follows the stream and the descriptor handshake
  always @(posedge clk) begin
    if (rst) begin
      exp_q.delete();
      stop_seen  = 1'b0;
      quiet      = 1'b0;
      beat_count = 0;
    end else begin
      if (beat_fire) begin
        beat_count++;
        if (exp_q.size() != 0)
          void'(exp_q.pop_front());
      end
      // FIFO is cleared one edge after the stop is registered
      if (stop_seen) begin
        exp_q.delete();
        quiet     = 1'b1;
        stop_seen = 1'b0;
      end
      if (accel_stop)
        stop_seen = 1'b1;
      if (desc_valid && desc_ready) begin
        quiet = 1'b0;
        push_expected(desc_addr, desc_len);
      end
    end
    exp_valid = (exp_q.size() != 0);
    exp_head  = exp_valid ? exp_q[0] : '0;
  end

  a_beat_expected: assert property (
    @(posedge clk) disable iff (rst) beat_fire |-> exp_valid
  ) else begin
    err_flow++;
    $display("A beat arrived on the stream when no beat was expected");
  end

  a_beat_data: assert property (
    @(posedge clk) disable iff (rst) (beat_fire && exp_valid)
      |-> ((m_axis_tdata & exp_head.mask) == (exp_head.data & exp_head.mask))
  ) else begin
    err_data++;
    $display("error m_axis_tdata expected %h actual %h",
             $sampled(exp_head.data & exp_head.mask), $sampled(m_axis_tdata & exp_head.mask));
  end

  a_beat_last: assert property (
    @(posedge clk) disable iff (rst) (beat_fire && exp_valid) |-> (m_axis_tlast == exp_head.last)
  ) else begin
    err_last++;
    $display("error m_axis_tlast expected %h actual %h",
             $sampled(exp_head.last), $sampled(m_axis_tlast));
  end

  a_beat_empty: assert property (
    @(posedge clk) disable iff (rst) (beat_fire && exp_valid) |-> (m_axis_tempty == exp_head.empty)
  ) else begin
    err_empty++;
    $display("error m_axis_tempty expected %h actual %h",
             $sampled(exp_head.empty), $sampled(m_axis_tempty));
  end

  a_hold_stable: assert property (
    @(posedge clk) disable iff (rst || stop_seen || quiet) (m_axis_tvalid && !m_axis_tready)
      |=> (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tempty)
           && $stable(m_axis_tlast))
  ) else begin
    err_stable++;
    $display("A waiting beat changed or was dropped before tready");
  end

  a_quiet_after_stop: assert property (
    @(posedge clk) disable iff (rst) quiet |-> !m_axis_tvalid
  ) else begin
    err_flow++;
    $display("m_axis_tvalid went high after accel_stop and before a new descriptor");
  end

  // With every expected beat delivered no transfer can still be active
  a_ready_when_idle: assert property (
    @(posedge clk) disable iff (rst) !exp_valid |-> desc_ready
  ) else begin
    err_flow++;
    $display("desc_ready was low while no transfer was outstanding");
  end

  task automatic load_memory();
    logic [31:0] word;
    line_t       line_data;
    for (int l = 0; l < NUM_LINES; l++) begin
      for (int w = 0; w < DATA_WIDTH / 32; w++) begin
        take_bits(32, word);
        line_data[32*w +: 32] = word;
      end
      for (int j = 0; j < LINE_BYTES; j++)
        mem_bytes[LINE_BYTES * l + j] = line_data[8*j +: 8];
      wr_en   = 1'b1;
      wr_addr = line_addr_t'(l);
      wr_data = line_data;
      @(negedge clk);
    end
    wr_en = 1'b0;
  endtask

  // Called on a falling edge and returns on the falling edge after acceptance
  task automatic send_desc(input byte_addr_t addr, input byte_len_t len, input logic hold);
    desc_addr  = addr;
    desc_len   = len;
    desc_valid = 1'b1;
    @(posedge clk);
    while (!desc_ready)
      @(posedge clk);
    @(negedge clk);
    if (!hold)
      desc_valid = 1'b0;
  endtask

  task automatic wait_idle();
    @(negedge clk);
    while (exp_q.size() != 0 || !desc_ready)
      @(negedge clk);
  endtask

  task automatic run_desc(input byte_addr_t addr, input byte_len_t len);
    send_desc(addr, len, 1'b0);
    wait_idle();
  endtask

  // Random tready is the only LFSR user while enabled
  always @(negedge clk) begin
    if (rand_ready) begin
      lfsr          = lfsr_step(lfsr);
      m_axis_tready = lfsr[0];
    end
  end

  initial begin
    logic [31:0] r;
    int          start;
    int          total;
    clk           = 1'b0;
    rst           = 1'b1;
    wr_en         = 1'b0;
    wr_addr       = '0;
    wr_data       = '0;
    desc_addr     = '0;
    desc_len      = '0;
    desc_valid    = 1'b0;
    accel_stop    = 1'b0;
    m_axis_tready = 1'b1;
    rand_ready    = 1'b0;
    lfsr          = 32'd95949;
    err_data      = 0;
    err_last      = 0;
    err_empty     = 0;
    err_stable    = 0;
    err_flow      = 0;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    load_memory();
    for (int i = 0; i < NUM_RAND; i++) begin
      take_bits(13, r);
      rnd_addr[i] = byte_addr_t'(r);
      take_bits(10, r);
      rnd_len[i] = (r[9:0] == '0) ? byte_len_t'(1) : byte_len_t'(r);
    end

    // Aligned, one, two and many lines
    run_desc(14'h0000, 10'd16);
    run_desc(14'h0040, 10'd32);
    run_desc(14'h0100, 10'd256);

    // Offsets 1, 7 and 15, odd start lines and block crossings
    run_desc(14'h0021, 10'd50);
    run_desc(14'h0037, 10'd33);
    run_desc(14'h004f, 10'd64);
    run_desc(14'h0ff1, 10'd40);
    run_desc(14'h0fef, 10'd70);
    run_desc(14'h1ff7, 10'd48);

    // Final empty count
    run_desc(14'h0123, 10'd1);
    run_desc(14'h0200, 10'd16);
    run_desc(14'h0305, 10'd17);
    run_desc(14'h0011, 10'd1023);

    rand_ready = 1'b1;
    for (int i = 0; i < NUM_RAND; i++)
      run_desc(rnd_addr[i], rnd_len[i]);
    rand_ready    = 1'b0;
    m_axis_tready = 1'b1;

    // desc_valid stays high across four descriptors
    send_desc(14'h0500, 10'd40, 1'b1);
    send_desc(14'h0613, 10'd25, 1'b1);
    send_desc(14'h0707, 10'd100, 1'b1);
    send_desc(14'h080f, 10'd3, 1'b0);
    wait_idle();

    send_desc(14'h0400, 10'd1000, 1'b0);
    start = beat_count;
    while (beat_count < start + 10)
      @(negedge clk);
    accel_stop = 1'b1;
    @(negedge clk);
    accel_stop = 1'b0;
    repeat (8) @(negedge clk);
    run_desc(14'h0a03, 10'd100);

    repeat (5) @(negedge clk);
    total = err_data + err_last + err_empty + err_stable + err_flow;
    $display("Errors: data %0d last %0d empty %0d stable %0d flow %0d",
             err_data, err_last, err_empty, err_stable, err_flow);
    if (total == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule

//--- accel_rd.f
mem_geom_pkg.sv
rd_stream_pkg.sv
bank_rd_if.sv
simple_fifo.sv
scratch_mem.sv
single_accel_rd_dma.sv
accel_rd_top.sv
tb_accel_rd.sv
